// ==== design/ccu_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the four-port snoop coherence controller
// Single-word transfers only, no bursts and no byte selects
// NUM_PORTS must stay a power of two, port indices wrap
////////////////////////////////////////////////////////////
package ccu_pkg;

    localparam int unsigned NUM_PORTS  = 4;
    localparam int unsigned PORT_IDX_W = 2;
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned DATA_W     = 32;

    typedef enum logic {
        SNP_READ  = 1'b0,
        SNP_INVAL = 1'b1
    } snp_op_e;

    // Wishbone classic, one word per cycle
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] data;
    } wb_rsp_t;

    typedef struct packed {
        logic              valid;
        snp_op_e           op;
        logic [ADDR_W-1:0] addr;
    } snoop_req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;
        logic [DATA_W-1:0] data;
    } snoop_rsp_t;

    typedef struct packed {
        logic [PORT_IDX_W-1:0] port;
        logic                  we;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
    } xact_t;

endpackage

// ==== design/ccu_req_arbiter.sv ====
////////////////////////////////////////////////////////////
// Round-robin request arbiter, one grant held until done
// Masters must keep cyc and stb high until their ack
// and drop stb in the cycle after it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_req_arbiter (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  ccu_pkg::wb_req_t [ccu_pkg::NUM_PORTS-1:0] port_req_i,
    output ccu_pkg::wb_rsp_t [ccu_pkg::NUM_PORTS-1:0] port_rsp_o,
    output ccu_pkg::xact_t                            xact_o,
    output logic                                      req_valid_o,
    input  logic                                      done_i,
    input  logic [ccu_pkg::DATA_W-1:0]                rsp_data_i
);
    import ccu_pkg::*;

    logic                  busy_q;
    logic [PORT_IDX_W-1:0] last_q;
    xact_t                 xact_q;
    logic [NUM_PORTS-1:0]  req_vec;
    logic [NUM_PORTS-1:0]  ack_vec;
    logic                  pick_valid;
    logic [PORT_IDX_W-1:0] pick_idx;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            req_vec[i]         = port_req_i[i].cyc && port_req_i[i].stb;
            ack_vec[i]         = busy_q && done_i && (last_q == PORT_IDX_W'(i));
            port_rsp_o[i].ack  = ack_vec[i];
            port_rsp_o[i].data = rsp_data_i;
        end
    end

    // Search starts after the last granted port, which comes last
    always_comb begin
        logic [PORT_IDX_W-1:0] idx;
        pick_valid = 1'b0;
        pick_idx   = last_q;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = last_q + PORT_IDX_W'(k);
            if (!pick_valid && req_vec[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            last_q <= PORT_IDX_W'(NUM_PORTS - 1);
        end else if (!busy_q) begin
            if (pick_valid) begin
                busy_q <= 1'b1;
                last_q <= pick_idx;
            end
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_q && pick_valid) begin
            xact_q.port <= pick_idx;
            xact_q.we   <= port_req_i[pick_idx].we;
            xact_q.addr <= port_req_i[pick_idx].addr;
            xact_q.data <= port_req_i[pick_idx].data;
        end
    end

    assign xact_o      = xact_q;
    assign req_valid_o = busy_q;

    // Ack goes only to a master that still holds its strobe
    a_ack_to_requester: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ack_vec & ~req_vec) == '0);

endmodule

// ==== design/ccu_dispatch.sv ====
////////////////////////////////////////////////////////////
// Transaction sequencer: snoop first, then memory if needed
// Read hits complete from snoop data, memory is untouched
// Writes always invalidate the other caches, then go to memory
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_dispatch (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  ccu_pkg::xact_t             xact_i,
    input  logic                       req_valid_i,
    output logic                       done_o,
    output logic [ccu_pkg::DATA_W-1:0] rsp_data_o,
    output logic                       snp_start_o,
    output ccu_pkg::snp_op_e           snp_op_o,
    input  logic                       snp_done_i,
    input  logic                       snp_hit_i,
    input  logic [ccu_pkg::DATA_W-1:0] snp_data_i,
    output logic                       mem_start_o,
    input  logic                       mem_done_i,
    input  logic [ccu_pkg::DATA_W-1:0] mem_data_i
);
    import ccu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SNOOP,
        MEM,
        DONE
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic              snp_start_d;
    logic              mem_start_d;
    logic [DATA_W-1:0] data_q;

    always_comb begin
        state_d     = state_q;
        snp_start_d = 1'b0;
        mem_start_d = 1'b0;
        unique case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d     = SNOOP;
                    snp_start_d = 1'b1;
                end
            end
            SNOOP: begin
                if (snp_done_i) begin
                    if (!xact_i.we && snp_hit_i) begin
                        state_d = DONE;
                    end else begin
                        state_d     = MEM;
                        mem_start_d = 1'b1;
                    end
                end
            end
            MEM: begin
                if (mem_done_i) state_d = DONE;
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            snp_start_o <= 1'b0;
            mem_start_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            snp_start_o <= snp_start_d;
            mem_start_o <= mem_start_d;
        end
    end

    // Response word, from the first snoop hit or from memory
    always_ff @(posedge clk_i) begin
        if (state_q == SNOOP && snp_done_i) begin
            data_q <= snp_data_i;
        end else if (state_q == MEM && mem_done_i) begin
            data_q <= mem_data_i;
        end
    end

    assign snp_op_o   = xact_i.we ? SNP_INVAL : SNP_READ;
    assign done_o     = (state_q == DONE);
    assign rsp_data_o = data_q;

    // A read that hit in a cache never starts a memory cycle
    a_hit_no_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_start_o |-> xact_i.we || !snp_hit_i);

endmodule

// ==== design/ccu_snoop_unit.sv ====
////////////////////////////////////////////////////////////
// Snoops every cache except the requester's own
// Waits for one answer per snooped cache, without timeout
// Keeps the data of the lowest-index cache that hit
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_snoop_unit (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         snp_start_i,
    input  ccu_pkg::snp_op_e                             snp_op_i,
    input  ccu_pkg::xact_t                               xact_i,
    output ccu_pkg::snoop_req_t [ccu_pkg::NUM_PORTS-1:0] snoop_req_o,
    input  ccu_pkg::snoop_rsp_t [ccu_pkg::NUM_PORTS-1:0] snoop_rsp_i,
    output logic                                         snp_done_o,
    output logic                                         snp_hit_o,
    output logic [ccu_pkg::DATA_W-1:0]                   snp_data_o
);
    import ccu_pkg::*;

    logic                  active_q;
    snp_op_e               op_q;
    logic [NUM_PORTS-1:0]  mask_q;
    logic [NUM_PORTS-1:0]  answered_q;
    logic [NUM_PORTS-1:0]  hit_q;
    logic                  done_q;
    logic [DATA_W-1:0]     data_q;
    logic [NUM_PORTS-1:0]  rsp_vec;
    logic [NUM_PORTS-1:0]  accept;
    logic [NUM_PORTS-1:0]  new_hit;
    logic [NUM_PORTS-1:0]  all_hit;
    logic [NUM_PORTS-1:0]  answered_d;
    logic [PORT_IDX_W-1:0] first_idx;
    logic                  last_answer;

    always_comb begin
        first_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            snoop_req_o[i].valid = active_q && mask_q[i];
            snoop_req_o[i].op    = op_q;
            snoop_req_o[i].addr  = xact_i.addr;
            rsp_vec[i]           = snoop_rsp_i[i].valid;
            accept[i]            = rsp_vec[i] && active_q && mask_q[i];
            new_hit[i]           = accept[i] && snoop_rsp_i[i].hit;
        end
        all_hit    = hit_q | new_hit;
        answered_d = answered_q | accept;
        // Lowest index wins, whether it hit earlier or in this cycle
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (all_hit[i]) first_idx = PORT_IDX_W'(i);
        end
        last_answer = active_q && (answered_d == mask_q);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q   <= 1'b0;
            op_q       <= SNP_READ;
            mask_q     <= '0;
            answered_q <= '0;
            hit_q      <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= last_answer;
            if (snp_start_i) begin
                active_q   <= 1'b1;
                op_q       <= snp_op_i;
                mask_q     <= ~(NUM_PORTS'(1) << xact_i.port);
                answered_q <= '0;
                hit_q      <= '0;
            end else if (active_q) begin
                answered_q <= answered_d;
                hit_q      <= all_hit;
                if (last_answer) active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_hit[first_idx]) data_q <= snoop_rsp_i[first_idx].data;
    end

    assign snp_done_o = done_q;
    assign snp_hit_o  = |hit_q;
    assign snp_data_o = data_q;

    // Only snooped caches answer, each one exactly once per snoop
    a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (rsp_vec & ~(mask_q & ~answered_q & {NUM_PORTS{active_q}})) == '0);

endmodule

// ==== design/ccu_mem_unit.sv ====
////////////////////////////////////////////////////////////
// Wishbone classic master towards memory, one word per cycle
// Address, we and data come straight from the held request
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_mem_unit (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       mem_start_i,
    input  ccu_pkg::xact_t             xact_i,
    output ccu_pkg::wb_req_t           mem_req_o,
    input  ccu_pkg::wb_rsp_t           mem_rsp_i,
    output logic                       mem_done_o,
    output logic [ccu_pkg::DATA_W-1:0] mem_data_o
);
    import ccu_pkg::*;

    logic              cyc_q;
    logic              done_q;
    logic [DATA_W-1:0] data_q;

    always_comb begin
        mem_req_o.cyc  = cyc_q;
        mem_req_o.stb  = cyc_q;
        mem_req_o.we   = xact_i.we;
        mem_req_o.addr = xact_i.addr;
        mem_req_o.data = xact_i.data;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= cyc_q && mem_rsp_i.ack;
            if (mem_start_i) begin
                cyc_q <= 1'b1;
            end else if (cyc_q && mem_rsp_i.ack) begin
                cyc_q <= 1'b0;
            end
        end
    end

    // Read word is captured on ack, ignored for writes
    always_ff @(posedge clk_i) begin
        if (cyc_q && mem_rsp_i.ack) data_q <= mem_rsp_i.data;
    end

    assign mem_done_o = done_q;
    assign mem_data_o = data_q;

    // Slave acks only inside a running cycle
    a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_i.ack |-> mem_req_o.cyc && mem_req_o.stb);

    // Request stays put until the slave acks
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.stb && !mem_rsp_i.ack
        |=> mem_req_o.stb && $stable(mem_req_o.addr) && $stable(mem_req_o.we));

endmodule

// ==== design/ccu_top.sv ====
////////////////////////////////////////////////////////////
// Snoop coherence controller for four processor ports
// One transaction in flight, caches and memory may stall it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_top (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  ccu_pkg::wb_req_t    [ccu_pkg::NUM_PORTS-1:0] port_req_i,
    output ccu_pkg::wb_rsp_t    [ccu_pkg::NUM_PORTS-1:0] port_rsp_o,
    output ccu_pkg::snoop_req_t [ccu_pkg::NUM_PORTS-1:0] snoop_req_o,
    input  ccu_pkg::snoop_rsp_t [ccu_pkg::NUM_PORTS-1:0] snoop_rsp_i,
    output ccu_pkg::wb_req_t                             mem_req_o,
    input  ccu_pkg::wb_rsp_t                             mem_rsp_i
);
    import ccu_pkg::*;

    xact_t             xact;
    logic              req_valid;
    logic              done;
    logic [DATA_W-1:0] rsp_data;
    logic              snp_start;
    snp_op_e           snp_op;
    logic              snp_done;
    logic              snp_hit;
    logic [DATA_W-1:0] snp_data;
    logic              mem_start;
    logic              mem_done;
    logic [DATA_W-1:0] mem_data;

    ccu_req_arbiter i_arbiter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .port_req_i  (port_req_i),
        .port_rsp_o  (port_rsp_o),
        .xact_o      (xact),
        .req_valid_o (req_valid),
        .done_i      (done),
        .rsp_data_i  (rsp_data)
    );

    ccu_dispatch i_dispatch (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .xact_i      (xact),
        .req_valid_i (req_valid),
        .done_o      (done),
        .rsp_data_o  (rsp_data),
        .snp_start_o (snp_start),
        .snp_op_o    (snp_op),
        .snp_done_i  (snp_done),
        .snp_hit_i   (snp_hit),
        .snp_data_i  (snp_data),
        .mem_start_o (mem_start),
        .mem_done_i  (mem_done),
        .mem_data_i  (mem_data)
    );

    ccu_snoop_unit i_snoop_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .snp_start_i (snp_start),
        .snp_op_i    (snp_op),
        .xact_i      (xact),
        .snoop_req_o (snoop_req_o),
        .snoop_rsp_i (snoop_rsp_i),
        .snp_done_o  (snp_done),
        .snp_hit_o   (snp_hit),
        .snp_data_o  (snp_data)
    );

    ccu_mem_unit i_mem_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mem_start_i (mem_start),
        .xact_i      (xact),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i),
        .mem_done_o  (mem_done),
        .mem_data_o  (mem_data)
    );

endmodule

// ==== verif/ccu_tb_models.sv ====
////////////////////////////////////////////////////////////
// Behavioral caches and memory for the coherence testbench
// Lines are loaded from outside through the lines array
// Unwritten memory words read back as an address pattern
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ccu_tb_models (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  ccu_pkg::snoop_req_t [ccu_pkg::NUM_PORTS-1:0] snoop_req_i,
    output ccu_pkg::snoop_rsp_t [ccu_pkg::NUM_PORTS-1:0] snoop_rsp_o,
    input  ccu_pkg::wb_req_t                             mem_req_i,
    output ccu_pkg::wb_rsp_t                             mem_rsp_o
);
    import ccu_pkg::*;

    logic [DATA_W-1:0] lines [NUM_PORTS][logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    snoop_rsp_t        rsp_q [NUM_PORTS];
    int unsigned       valid_timeouts;

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return {addr[15:0], addr[31:16]} ^ 32'h3C96_A5E1;
    endfunction

    initial valid_timeouts = 0;

    always_comb begin
        for (int c = 0; c < NUM_PORTS; c++) snoop_rsp_o[c] = rsp_q[c];
    end

    for (genvar c = 0; c < NUM_PORTS; c++) begin : g_cache
        initial begin
            int unsigned delay;
            int unsigned n;
            rsp_q[c] = '0;
            forever begin
                @(posedge clk_i);
                if (rst_ni && snoop_req_i[c].valid) begin
                    delay = $urandom_range(5, 1);
                    repeat (delay - 1) @(posedge clk_i);
                    rsp_q[c] <= '{valid: 1'b1, hit: lines[c].exists(snoop_req_i[c].addr),
                                  data: lines[c].exists(snoop_req_i[c].addr) ?
                                        lines[c][snoop_req_i[c].addr] : '0};
                    if (snoop_req_i[c].op == SNP_INVAL) lines[c].delete(snoop_req_i[c].addr);
                    @(posedge clk_i);
                    rsp_q[c] <= '0;
                    // Valid stays up until the slowest cache has answered
                    n = 0;
                    while (snoop_req_i[c].valid && n < 100) begin
                        @(posedge clk_i);
                        n++;
                    end
                    if (snoop_req_i[c].valid) begin
                        $display("Cache %0d saw its snoop valid stay high after the answer", c);
                        valid_timeouts++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory slave
    ////////////////////////////////////////////////////////////
    initial begin
        int unsigned delay;
        mem_rsp_o = '0;
        forever begin
            @(posedge clk_i);
            if (rst_ni && mem_req_i.cyc && mem_req_i.stb) begin
                delay = $urandom_range(6, 1);
                repeat (delay - 1) @(posedge clk_i);
                if (mem_req_i.we) mem[mem_req_i.addr] = mem_req_i.data;
                mem_rsp_o <= '{ack: 1'b1, data: read_word(mem_req_i.addr)};
                @(posedge clk_i);
                mem_rsp_o <= '0;
            end
        end
    end

endmodule

// ==== verif/tb_ccu.sv ====
////////////////////////////////////////////////////////////
// Testbench for the snoop coherence controller
// Directed cases first, then random traffic from seed 98
// Expected data comes from a reference copy of caches and memory
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ccu;
    import ccu_pkg::*;

    localparam int unsigned TIMEOUT = 200;

    logic                       clk;
    logic                       rst_n;
    wb_req_t    [NUM_PORTS-1:0] port_req;
    wb_rsp_t    [NUM_PORTS-1:0] port_rsp;
    snoop_req_t [NUM_PORTS-1:0] snoop_req;
    snoop_rsp_t [NUM_PORTS-1:0] snoop_rsp;
    wb_req_t                    mem_req;
    wb_rsp_t                    mem_rsp;

    logic [DATA_W-1:0]    ref_lines [NUM_PORTS][logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]    ref_mem [logic [ADDR_W-1:0]];
    logic [NUM_PORTS-1:0] pending;
    logic [NUM_PORTS-1:0] seen_mask;
    snp_op_e              seen_op [NUM_PORTS];
    logic [ADDR_W-1:0]    seen_addr [NUM_PORTS];
    int unsigned          mem_cycles;
    int unsigned          last_served;
    int unsigned          errors;
    int unsigned          checks;
    int unsigned          tests_run;
    int unsigned          tests_failed;

    ccu_top i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .port_req_i  (port_req),
        .port_rsp_o  (port_rsp),
        .snoop_req_o (snoop_req),
        .snoop_rsp_i (snoop_rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    ccu_tb_models i_models (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .snoop_req_i (snoop_req),
        .snoop_rsp_o (snoop_rsp),
        .mem_req_i   (mem_req),
        .mem_rsp_o   (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // What the caches and memory saw during the current transaction
    always @(posedge clk) begin
        int unsigned acks;
        acks = 0;
        for (int c = 0; c < NUM_PORTS; c++) begin
            if (port_rsp[c].ack) acks++;
            if (snoop_req[c].valid) begin
                seen_mask[c] = 1'b1;
                seen_op[c]   = snoop_req[c].op;
                seen_addr[c] = snoop_req[c].addr;
            end
        end
        if (mem_req.cyc && mem_req.stb && mem_rsp.ack) mem_cycles++;
        if (acks > 1) begin
            $display("More than one port was acked in the same cycle");
            errors++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic logic [ADDR_W-1:0] pool_addr(input int unsigned k);
        return 32'h0000_1000 + (k << 2);
    endfunction

    function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr)) return ref_mem[addr];
        return {addr[15:0], addr[31:16]} ^ 32'h3C96_A5E1;
    endfunction

    task automatic preload(input int unsigned c, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
        i_models.lines[c][addr] = data;
        ref_lines[c][addr]      = data;
    endtask

    task automatic check_idle();
        logic [NUM_PORTS-1:0] acks;
        logic [NUM_PORTS-1:0] valids;
        for (int c = 0; c < NUM_PORTS; c++) begin
            acks[c]   = port_rsp[c].ack;
            valids[c] = snoop_req[c].valid;
        end
        check_value("port_ack", acks, '0);
        check_value("snoop_valid", valids, '0);
        check_value("mem_cyc", mem_req.cyc, 1'b0);
    endtask

    task automatic check_completion(input int unsigned p, input logic wr,
                                    input logic [ADDR_W-1:0] addr,
                                    input logic [DATA_W-1:0] data,
                                    input logic [DATA_W-1:0] rdata);
        int                   holder;
        int unsigned          exp_port;
        logic [NUM_PORTS-1:0] exp_mask;
        holder   = -1;
        exp_port = last_served;
        exp_mask = ~(NUM_PORTS'(1) << p);
        // Round robin, first pending port after the last one served
        for (int k = NUM_PORTS; k >= 1; k--) begin
            if (pending[(last_served + k) % NUM_PORTS]) begin
                exp_port = (last_served + k) % NUM_PORTS;
            end
        end
        for (int c = NUM_PORTS - 1; c >= 0; c--) begin
            if (c != p && ref_lines[c].exists(addr)) holder = c;
        end
        check_value("grant_port", p, exp_port);
        check_value("snoop_mask", seen_mask, exp_mask);
        for (int c = 0; c < NUM_PORTS; c++) begin
            if (exp_mask[c]) begin
                check_value("snoop_op", seen_op[c], wr ? SNP_INVAL : SNP_READ);
                check_value("snoop_addr", seen_addr[c], addr);
            end
        end
        if (!wr && holder >= 0) begin
            check_value("read_data", rdata, ref_lines[holder][addr]);
            check_value("mem_cycles", mem_cycles, 0);
        end else if (!wr) begin
            check_value("read_data", rdata, ref_word(addr));
            check_value("mem_cycles", mem_cycles, 1);
        end else begin
            ref_mem[addr] = data;
            for (int c = 0; c < NUM_PORTS; c++) begin
                if (c != p) ref_lines[c].delete(addr);
            end
            check_value("mem_cycles", mem_cycles, 1);
            check_value("mem_word", i_models.read_word(addr), data);
        end
        pending[p]  = 1'b0;
        last_served = p;
        seen_mask   = '0;
        mem_cycles  = 0;
    endtask

    task automatic finish_run();
        errors = errors + i_models.valid_timeouts;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic serve_port(input int unsigned p, input logic wr,
                              input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int unsigned n;
        @(posedge clk);
        pending[p]  = 1'b1;
        port_req[p] <= '{cyc: 1'b1, stb: 1'b1, we: wr, addr: addr, data: data};
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!port_rsp[p].ack && n < TIMEOUT);
        if (!port_rsp[p].ack) begin
            $display("Port %0d got no ack within %0d cycles", p, TIMEOUT);
            errors++;
            finish_run();
        end else begin
            port_req[p] <= '0;
            check_completion(p, wr, addr, data, port_rsp[p].data);
        end
    endtask

    task automatic end_test(input string name, input int unsigned err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
    endtask

    initial begin
        int unsigned       err_mark;
        logic              r_we   [NUM_PORTS];
        logic [ADDR_W-1:0] r_addr [NUM_PORTS];
        logic [DATA_W-1:0] r_data [NUM_PORTS];
        void'($urandom(98));
        rst_n        = 1'b0;
        port_req     = '0;
        pending      = '0;
        seen_mask    = '0;
        mem_cycles   = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        // Nothing served yet, so the search begins at port 0
        last_served  = NUM_PORTS - 1;
        for (int c = 0; c < NUM_PORTS; c++) begin
            repeat (3) preload(c, pool_addr($urandom_range(15, 0)), $urandom);
        end

        err_mark = errors;
        repeat (8) begin
            @(posedge clk);
            check_idle();
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle();
        end_test("reset_state", err_mark);

        err_mark = errors;
        serve_port(0, 1'b0, 32'h0000_2000, '0);
        end_test("read_miss", err_mark);

        // Own cache holds the line too and must stay out of the snoop
        err_mark = errors;
        preload(1, 32'h0000_2100, 32'h1111_0001);
        preload(2, 32'h0000_2100, 32'h2222_0002);
        preload(3, 32'h0000_2100, 32'h3333_0003);
        serve_port(1, 1'b0, 32'h0000_2100, '0);
        end_test("read_hit", err_mark);

        err_mark = errors;
        preload(0, 32'h0000_2200, 32'hAAAA_0000);
        preload(1, 32'h0000_2200, 32'hAAAA_0001);
        preload(3, 32'h0000_2200, 32'hAAAA_0003);
        serve_port(2, 1'b1, 32'h0000_2200, 32'hCAFE_0022);
        serve_port(0, 1'b0, 32'h0000_2200, '0);
        end_test("write_invalidate", err_mark);

        err_mark = errors;
        repeat (5) begin
            for (int c = 0; c < NUM_PORTS; c++) begin
                r_we[c]   = $urandom_range(1, 0);
                r_addr[c] = pool_addr($urandom_range(15, 0));
                r_data[c] = $urandom;
            end
            fork
                serve_port(0, r_we[0], r_addr[0], r_data[0]);
                serve_port(1, r_we[1], r_addr[1], r_data[1]);
                serve_port(2, r_we[2], r_addr[2], r_data[2]);
                serve_port(3, r_we[3], r_addr[3], r_data[3]);
            join
        end
        end_test("fair_arbitration", err_mark);

        err_mark = errors;
        repeat (30) begin
            if ($urandom_range(3, 0) == 0) begin
                preload($urandom_range(3, 0), pool_addr($urandom_range(15, 0)), $urandom);
            end
            serve_port($urandom_range(3, 0), $urandom_range(1, 0),
                       pool_addr($urandom_range(15, 0)), $urandom);
        end
        end_test("random_sequence", err_mark);

        finish_run();
    end

endmodule

// ==== list.f ====
design/ccu_pkg.sv
design/ccu_req_arbiter.sv
design/ccu_dispatch.sv
design/ccu_snoop_unit.sv
design/ccu_mem_unit.sv
design/ccu_top.sv
verif/ccu_tb_models.sv
verif/tb_ccu.sv
